// File: verilog/mvm_pkg.sv
package mvm_pkg;

	// Vector geometry
	localparam int LANES = 4;
	localparam int ELEMW = 16;
	localparam int VECW  = LANES * ELEMW;
	localparam int ACCW  = 32;
	localparam int USERW = 16;

	// Per-lane register file and instruction memory sizes
	localparam int RF_DEPTH   = 16;
	localparam int RF_ADDRW   = $clog2(RF_DEPTH);
	localparam int INST_DEPTH = 16;
	localparam int INST_ADDRW = $clog2(INST_DEPTH);

	// Issue to result: row read, products, sum
	localparam int LANE_LATENCY = 3;

	typedef logic signed [ELEMW-1:0] elem_t;

	typedef elem_t [LANES-1:0] vec_t;

	// For a jump, rf_raddr carries the target address
	typedef struct packed {
		logic [RF_ADDRW-1:0] rf_raddr;
		logic                last;
		logic                jump;
		logic                en;
	} inst_t;

	typedef struct packed {
		logic [VECW-$bits(inst_t)-1:0] pad;
		inst_t                         inst;
	} inst_word_t;

	// One receive word, read as an instruction or as a vector depending on its kind
	typedef union packed {
		inst_word_t inst_word;
		vec_t       vec;
	} rx_word_u;

	typedef enum logic [1:0] {
		KIND_INST = 2'd0,
		KIND_VEC  = 2'd2,
		KIND_ROW  = 2'd3
	} rx_kind_e;

endpackage

// File: verilog/mvm_lane_if.sv
interface mvm_lane_if import mvm_pkg::*; #(
	parameter int DPES = 4
) ();

	// Row writes into the lane register files
	logic [DPES-1:0]     wr_mask;
	logic [RF_ADDRW-1:0] wr_addr;
	vec_t                wr_data;

	// Dot-product issue
	logic [RF_ADDRW-1:0] rd_addr;
	logic                issue;
	vec_t                vec;

	modport steer (
		output wr_mask,
		output wr_addr,
		output wr_data
	);

	modport seq (
		output rd_addr,
		output issue,
		output vec
	);

	modport lane (
		input wr_mask,
		input wr_addr,
		input wr_data,
		input rd_addr,
		input issue,
		input vec
	);

endinterface

// File: verilog/mvm_fifo.sv
module mvm_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 8
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       push,
	input  logic [WIDTH-1:0]           idata,
	input  logic                       pop,
	output logic [WIDTH-1:0]           odata,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH):0]     count
);

	localparam int ADDRW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [ADDRW-1:0] wr_ptr;
	logic [ADDRW-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= idata;
		end
	end

	// Pointers wrap explicitly so a depth that is not a power of two still works
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ADDRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ADDRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	assign odata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == ($clog2(DEPTH) + 1)'(DEPTH));

endmodule

// File: verilog/mvm_rx_steer.sv
module mvm_rx_steer import mvm_pkg::*; #(
	parameter int DPES = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rx_valid,
	input  rx_kind_e              rx_kind,
	input  rx_word_u              rx_data,
	input  logic [USERW-1:0]      rx_user,
	output logic                  inst_wen,
	output logic [INST_ADDRW-1:0] inst_waddr,
	output inst_t                 inst_wdata,
	output logic                  vec_push,
	output vec_t                  vec_data,
	mvm_lane_if.steer             lane
);

	logic is_inst;
	logic is_row;
	logic is_vec;

	// The user field must hold a row address and one mask bit per lane
	if (RF_ADDRW + DPES > USERW) begin : gen_user_check
		$error("rx_user too narrow for the lane mask");
	end

	// Kind code 1 matches none of these and the word is dropped
	assign is_inst = rx_valid && (rx_kind == KIND_INST);
	assign is_row  = rx_valid && (rx_kind == KIND_ROW);
	assign is_vec  = rx_valid && (rx_kind == KIND_VEC);

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_wen     <= 1'b0;
			vec_push     <= 1'b0;
			lane.wr_mask <= '0;
		end else begin
			inst_wen     <= is_inst;
			vec_push     <= is_vec;
			lane.wr_mask <= is_row ? rx_user[RF_ADDRW +: DPES] : '0;
		end
	end

	// The same word is taken as an instruction or a vector, the strobes decide which
	always_ff @(posedge clk) begin
		inst_waddr   <= rx_user[INST_ADDRW-1:0];
		inst_wdata   <= rx_data.inst_word.inst;
		vec_data     <= rx_data.vec;
		lane.wr_addr <= rx_user[RF_ADDRW-1:0];
		lane.wr_data <= rx_data.vec;
	end

endmodule

// File: verilog/mvm_sequencer.sv
module mvm_sequencer import mvm_pkg::*; #(
	parameter int DPES       = 4,
	parameter int INPT_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_wen,
	input  logic [INST_ADDRW-1:0] inst_waddr,
	input  inst_t                 inst_wdata,
	input  logic                  vec_push,
	input  vec_t                  vec_data,
	input  logic                  space_ok,
	output logic                  rx_credit,
	mvm_lane_if.seq               lane
);

	inst_t                 inst_mem [INST_DEPTH];
	logic [INST_ADDRW-1:0] pc;
	inst_t                 cur;
	vec_t                  vec_head;
	logic                  vec_empty;
	logic                  do_issue;
	logic                  do_jump;
	logic                  vec_pop;

	if (DPES < 1 || INPT_DEPTH < 2) begin : gen_cfg_check
		$error("sequencer needs at least one lane and two input entries");
	end

	// Input vectors wait here until the last step of the program has used them
	mvm_fifo #(
		.WIDTH(VECW),
		.DEPTH(INPT_DEPTH)
	) i_input_fifo (
		.clk  (clk),
		.rst  (rst),
		.push (vec_push),
		.idata(vec_data),
		.pop  (vec_pop),
		.odata(vec_head),
		.empty(vec_empty),
		.full (),
		.count()
	);

	// Entries come out of reset disabled so the program halts at address 0
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < INST_DEPTH; i++) begin
				inst_mem[i] <= '0;
			end
		end else if (inst_wen) begin
			inst_mem[inst_waddr] <= inst_wdata;
		end
	end

	assign cur = inst_mem[pc];

	assign do_issue = cur.en && !cur.jump && !vec_empty && space_ok;
	assign do_jump  = cur.en && cur.jump;
	assign vec_pop  = do_issue && cur.last;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= '0;
			lane.issue <= 1'b0;
			rx_credit  <= 1'b0;
		end else begin
			lane.issue <= do_issue;
			rx_credit  <= vec_pop;
			if (do_jump) begin
				pc <= INST_ADDRW'(cur.rf_raddr);
			end else if (do_issue) begin
				pc <= pc + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		lane.rd_addr <= cur.rf_raddr;
		lane.vec     <= vec_head;
	end

endmodule

// File: verilog/mvm_dot_lane.sv
module mvm_dot_lane import mvm_pkg::*; #(
	parameter int LANE_ID = 0
) (
	input  logic                   clk,
	input  logic                   rst,
	mvm_lane_if.lane               lane,
	output logic signed [ACCW-1:0] result,
	output logic                   rvalid
);

	vec_t                      rf [RF_DEPTH];
	vec_t                      row_q;
	vec_t                      vec_q;
	logic signed [2*ELEMW-1:0] prod_q [LANES];
	logic signed [ACCW-1:0]    sum;
	logic                      v1;
	logic                      v2;

	always_ff @(posedge clk) begin
		if (lane.wr_mask[LANE_ID]) begin
			rf[lane.wr_addr] <= lane.wr_data;
		end
	end

	// Stage 1 reads the row next to the issued vector, stage 2 multiplies, stage 3 sums
	always_ff @(posedge clk) begin
		row_q <= rf[lane.rd_addr];
		vec_q <= lane.vec;
		for (int i = 0; i < LANES; i++) begin
			prod_q[i] <= row_q[i] * vec_q[i];
		end
		result <= sum;
	end

	always_comb begin
		sum = '0;
		for (int i = 0; i < LANES; i++) begin
			sum = sum + ACCW'(prod_q[i]);
		end
	end

	// Valid bits walk alongside the data, so back-to-back issues overlap freely
	always_ff @(posedge clk) begin
		if (rst) begin
			v1     <= 1'b0;
			v2     <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			v1     <= lane.issue;
			v2     <= v1;
			rvalid <= v2;
		end
	end

endmodule

// File: verilog/mvm_tx_drain.sv
module mvm_tx_drain import mvm_pkg::*; #(
	parameter int DPES       = 4,
	parameter int OUPT_DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [DPES*ACCW-1:0]   results,
	input  logic                   rvalid,
	input  logic                   tx_credit,
	output logic                   space_ok,
	output logic                   tx_valid,
	output logic [DPES*ACCW-1:0]   tx_data
);

	localparam int CNTW  = $clog2(OUPT_DEPTH) + 1;
	localparam int CREDW = 16;

	logic [CNTW-1:0]  out_count;
	logic [CNTW-1:0]  free_cnt;
	logic             out_empty;
	logic             out_full;
	logic [CREDW-1:0] credit_cnt;

	mvm_fifo #(
		.WIDTH(DPES * ACCW),
		.DEPTH(OUPT_DEPTH)
	) i_output_fifo (
		.clk  (clk),
		.rst  (rst),
		.push (rvalid),
		.idata(results),
		.pop  (tx_valid),
		.odata(tx_data),
		.empty(out_empty),
		.full (out_full),
		.count(out_count)
	);

	// Up to LANE_LATENCY issues are still in the lanes and one more is being decided,
	// so a new issue needs that much room beyond what the FIFO already holds
	assign free_cnt = CNTW'(OUPT_DEPTH) - out_count;
	assign space_ok = free_cnt > CNTW'(LANE_LATENCY + 1);

	assign tx_valid = (credit_cnt != '0) && !out_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= '0;
		end else if (tx_credit && !tx_valid) begin
			credit_cnt <= credit_cnt + 1'b1;
		end else if (tx_valid && !tx_credit) begin
			credit_cnt <= credit_cnt - 1'b1;
		end
	end

endmodule

// File: verilog/mvm_top.sv
module mvm_top import mvm_pkg::*; #(
	parameter int DPES       = 4,
	parameter int INPT_DEPTH = 4,
	parameter int OUPT_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rx_valid,
	input  rx_kind_e             rx_kind,
	input  logic [VECW-1:0]      rx_data,
	input  logic [USERW-1:0]     rx_user,
	output logic                 rx_credit,
	output logic                 tx_valid,
	output logic [DPES*ACCW-1:0] tx_data,
	input  logic                 tx_credit
);

	logic                  inst_wen;
	logic [INST_ADDRW-1:0] inst_waddr;
	inst_t                 inst_wdata;
	logic                  vec_push;
	vec_t                  vec_data;
	logic                  space_ok;
	logic [DPES*ACCW-1:0]  results;
	logic [DPES-1:0]       lane_rvalid;

	mvm_lane_if #(.DPES(DPES)) lane_bus ();

	mvm_rx_steer #(
		.DPES(DPES)
	) i_steer (
		.clk       (clk),
		.rst       (rst),
		.rx_valid  (rx_valid),
		.rx_kind   (rx_kind),
		.rx_data   (rx_data),
		.rx_user   (rx_user),
		.inst_wen  (inst_wen),
		.inst_waddr(inst_waddr),
		.inst_wdata(inst_wdata),
		.vec_push  (vec_push),
		.vec_data  (vec_data),
		.lane      (lane_bus.steer)
	);

	mvm_sequencer #(
		.DPES      (DPES),
		.INPT_DEPTH(INPT_DEPTH)
	) i_seq (
		.clk       (clk),
		.rst       (rst),
		.inst_wen  (inst_wen),
		.inst_waddr(inst_waddr),
		.inst_wdata(inst_wdata),
		.vec_push  (vec_push),
		.vec_data  (vec_data),
		.space_ok  (space_ok),
		.rx_credit (rx_credit),
		.lane      (lane_bus.seq)
	);

	for (genvar i = 0; i < DPES; i++) begin : gen_lane
		mvm_dot_lane #(
			.LANE_ID(i)
		) i_lane (
			.clk   (clk),
			.rst   (rst),
			.lane  (lane_bus.lane),
			.result(results[i*ACCW +: ACCW]),
			.rvalid(lane_rvalid[i])
		);
	end

	// All lanes run in lockstep, lane 0 speaks for the row
	mvm_tx_drain #(
		.DPES      (DPES),
		.OUPT_DEPTH(OUPT_DEPTH)
	) i_drain (
		.clk      (clk),
		.rst      (rst),
		.results  (results),
		.rvalid   (lane_rvalid[0]),
		.tx_credit(tx_credit),
		.space_ok (space_ok),
		.tx_valid (tx_valid),
		.tx_data  (tx_data)
	);

endmodule

// File: testbench/mvm_assert.sv
module mvm_assert (
	input logic clk,
	input logic rst,
	input logic tx_valid,
	input logic tx_credit,
	input logic rvalid,
	input logic out_full,
	input logic space_ok
);

	logic [15:0] granted;

	// Credits granted at the transmit port minus words already sent
	always_ff @(posedge clk) begin
		if (rst) begin
			granted <= '0;
		end else begin
			granted <= granted + 16'(tx_credit) - 16'(tx_valid);
		end
	end

	// A word leaves only against a held credit
	a_tx_credit: assert property (@(posedge clk) disable iff (rst) tx_valid |-> granted != '0)
		else $error("tx_valid raised with no transmit credit");

	a_push_full: assert property (@(posedge clk) disable iff (rst) rvalid |-> !out_full)
		else $error("lane result pushed into a full output FIFO");

	a_space_full: assert property (@(posedge clk) disable iff (rst) out_full |-> !space_ok)
		else $error("space_ok high while the output FIFO is full");

endmodule

bind mvm_tx_drain mvm_assert i_assert (
	.clk       (clk),
	.rst       (rst),
	.tx_valid  (tx_valid),
	.tx_credit (tx_credit),
	.rvalid    (rvalid),
	.out_full  (out_full),
	.space_ok  (space_ok)
);

// File: testbench/mvm_tb.sv
module mvm_tb import mvm_pkg::*; ();

	localparam int DPES       = 4;
	localparam int INPT_DEPTH = 4;
	localparam int OUPT_DEPTH = 8;
	localparam int WORDW      = DPES * ACCW;
	localparam int NVEC       = 20;
	localparam int NPHASE     = 3;
	localparam int MAX_STEPS  = 3;
	localparam int HOLD_PHASE = 2;
	// Each vector costs its steps plus the jump, with slack for latency and drains
	localparam int MAX_CYCLES = NVEC * (MAX_STEPS + 1 + 20) + RF_DEPTH * DPES + 100;

	typedef logic [WORDW-1:0] word_t;

	logic            clk;
	logic            rst;
	logic            rx_valid;
	rx_kind_e        rx_kind;
	logic [VECW-1:0] rx_data;
	logic [USERW-1:0] rx_user;
	logic            rx_credit;
	logic            tx_valid;
	word_t           tx_data;
	logic            tx_credit;

	// Stimulus table: phase, vector and the expected result of every program step
	int    tab_phase [NVEC];
	vec_t  tab_vec   [NVEC];
	word_t tab_exp   [NVEC][MAX_STEPS];
	int    prog_steps [NPHASE] = '{1, 3, 3};
	int    prog_rows  [NPHASE][MAX_STEPS] = '{'{5, 0, 0}, '{1, 7, 12}, '{1, 7, 12}};

	vec_t  rows [DPES][RF_DEPTH];
	word_t exp_q [$];
	int    seed = 32'h1f3;
	int    errors;
	int    checks;
	int    cycles;
	int    sender_credits;
	int    credit_pulses;
	int    received;
	int    owed;
	int    total_exp;
	bit    grant_en;
	bit    hold_tx;
	bit    starved;

	mvm_top #(
		.DPES      (DPES),
		.INPT_DEPTH(INPT_DEPTH),
		.OUPT_DEPTH(OUPT_DEPTH)
	) i_dut (
		.clk      (clk),
		.rst      (rst),
		.rx_valid (rx_valid),
		.rx_kind  (rx_kind),
		.rx_data  (rx_data),
		.rx_user  (rx_user),
		.rx_credit(rx_credit),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.tx_credit(tx_credit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_result(input word_t got, input word_t exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	function automatic logic signed [ACCW-1:0] dot(input vec_t v, input vec_t row);
		int acc = 0;
		for (int i = 0; i < LANES; i++) begin
			acc += int'($signed(v[i])) * int'($signed(row[i]));
		end
		return acc;
	endfunction

	function automatic word_t expect_word(input vec_t v, input int r);
		word_t w;
		for (int l = 0; l < DPES; l++) begin
			w[l*ACCW +: ACCW] = dot(v, rows[l][r]);
		end
		return w;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_word(input rx_kind_e kind, input logic [VECW-1:0] data, input int user);
		rx_valid = 1'b1;
		rx_kind  = kind;
		rx_data  = data;
		rx_user  = USERW'(user);
		next_cycle();
		rx_valid = 1'b0;
	endtask

	task automatic load_program(input int p);
		inst_t inst;
		for (int s = 0; s < prog_steps[p]; s++) begin
			inst = '{rf_raddr: RF_ADDRW'(prog_rows[p][s]), last: (s == prog_steps[p] - 1),
				jump: 1'b0, en: 1'b1};
			send_word(KIND_INST, VECW'(inst), s);
		end
		inst = '{rf_raddr: '0, last: 1'b0, jump: 1'b1, en: 1'b1};
		send_word(KIND_INST, VECW'(inst), prog_steps[p]);
	endtask

	task automatic send_vector(input int i);
		int p;
		int idle;
		p = tab_phase[i];
		while (sender_credits == 0) begin
			idle = 0;
			while (sender_credits == 0 && idle < 20) begin
				next_cycle();
				idle++;
			end
			// Out of credits with nothing draining, so the transmit side is opened
			if (sender_credits == 0 && hold_tx) begin
				starved  = 1'b1;
				hold_tx  = 1'b0;
				grant_en = 1'b1;
			end
		end
		send_word(KIND_VEC, tab_vec[i], 0);
		sender_credits--;
		for (int s = 0; s < prog_steps[p]; s++) begin
			exp_q.push_back(tab_exp[i][s]);
		end
		owed += prog_steps[p];
		total_exp += prog_steps[p];
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || owed != 0) begin
			next_cycle();
		end
		repeat (10) next_cycle();
	endtask

	// Grants one transmit credit per expected result, so the DUT ends each phase with none
	always @(posedge clk) begin
		#1;
		if (grant_en && owed > 0) begin
			tx_credit = 1'b1;
			owed--;
		end else begin
			tx_credit = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (rx_credit === 1'b1) begin
			sender_credits++;
			credit_pulses++;
		end
		if (hold_tx) begin
			check_bit(tx_valid, 1'b0, "tx_valid");
		end
		if (tx_valid === 1'b1) begin
			received++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("result word %h arrived at %0t with none expected", tx_data, $time);
			end else begin
				check_result(tx_data, exp_q.pop_front(), "tx_data");
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles with %0d errors", MAX_CYCLES, errors);
		$display("Test failures found");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		rx_valid  = 1'b0;
		rx_kind   = KIND_INST;
		rx_data   = '0;
		rx_user   = '0;
		tx_credit = 1'b0;
		errors = 0;
		checks = 0;
		credit_pulses = 0;
		received = 0;
		owed = 0;
		total_exp = 0;
		sender_credits = INPT_DEPTH;
		grant_en = 1'b0;
		hold_tx  = 1'b0;
		starved  = 1'b0;
		for (int l = 0; l < DPES; l++) begin
			for (int r = 0; r < RF_DEPTH; r++) begin
				for (int e = 0; e < LANES; e++) begin
					rows[l][r][e] = elem_t'($random(seed));
				end
			end
		end
		for (int i = 0; i < NVEC; i++) begin
			tab_phase[i] = (i < 4) ? 0 : ((i < 10) ? 1 : HOLD_PHASE);
			for (int e = 0; e < LANES; e++) begin
				tab_vec[i][e] = elem_t'($random(seed));
			end
			for (int s = 0; s < MAX_STEPS; s++) begin
				tab_exp[i][s] = (s < prog_steps[tab_phase[i]]) ?
					expect_word(tab_vec[i], prog_rows[tab_phase[i]][s]) : '0;
			end
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// Nothing may leave the design before any program or credit exists
		repeat (5) begin
			next_cycle();
			check_bit(tx_valid, 1'b0, "tx_valid");
			check_bit(rx_credit, 1'b0, "rx_credit");
		end
		for (int l = 0; l < DPES; l++) begin
			for (int r = 0; r < RF_DEPTH; r++) begin
				send_word(KIND_ROW, rows[l][r], ((1 << l) << RF_ADDRW) | r);
			end
		end
		for (int i = 0; i < NVEC; i++) begin
			if (i == 0 || tab_phase[i] != tab_phase[i-1]) begin
				if (i != 0) begin
					wait_drain();
				end
				load_program(tab_phase[i]);
				hold_tx  = (tab_phase[i] == HOLD_PHASE);
				grant_en = !hold_tx;
			end
			send_vector(i);
		end
		wait_drain();
		if (!starved) begin
			errors++;
			$display("sender credits never ran out while transmit credits were held back");
		end
		if (credit_pulses != NVEC) begin
			errors++;
			$display("saw %0d rx_credit pulses for %0d vectors", credit_pulses, NVEC);
		end
		if (received != total_exp) begin
			errors++;
			$display("received %0d result words, expected %0d", received, total_exp);
		end
		$display("checks %0d, errors %0d, results %0d", checks, errors, received);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: sim.f
verilog/mvm_pkg.sv
verilog/mvm_lane_if.sv
verilog/mvm_fifo.sv
verilog/mvm_rx_steer.sv
verilog/mvm_sequencer.sv
verilog/mvm_dot_lane.sv
verilog/mvm_tx_drain.sv
verilog/mvm_top.sv
testbench/mvm_assert.sv
testbench/mvm_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module mvm_tb -o mvm_sim

./obj_dir/mvm_sim | tee sim.log

grep -q "All tests passed!" sim.log
echo "simulation passed"
